/* hdl/bpu_consts.svh */
`ifndef BPU_CONSTS_SVH
`define BPU_CONSTS_SVH

// datapath
`define BPU_XLEN          32      // pc and instruction width
`define BPU_GHIST_W       16      // global history bits

// bimodal base table
`define BPU_BIM_ENTRIES   512
`define BPU_BIM_IDX_W     9

// tagged tables T0 and T1
`define BPU_TAGE_ENTRIES  256
`define BPU_TAGE_IDX_W    8
`define BPU_TAG_W         10
`define BPU_PTAG_W        6       // upper tag bits compared at lookup

// direct-mapped BTB
`define BPU_BTB_ENTRIES   256
`define BPU_BTB_IDX_W     8
`define BPU_BTB_TAG_W     22      // pc bits above the index

// RV32 major opcodes of control instructions
`define BPU_OP_BRANCH     7'b1100011
`define BPU_OP_JAL        7'b1101111
`define BPU_OP_JALR       7'b1100111

`endif

/* hdl/bpu_isa_pkg.sv */
`include "bpu_consts.svh"

// instruction encoding view of the fetch stream
package bpu_isa_pkg;

    // program counter or branch target
    typedef logic [`BPU_XLEN-1:0] addr_t;

    // raw 32-bit instruction word
    typedef logic [`BPU_XLEN-1:0] inst_t;

    // control class after pre-decode
    typedef enum logic [1:0] {
        cls_other  = 2'd0,
        cls_branch = 2'd1,      // conditional, B-type
        cls_jal    = 2'd2,      // direct jump, J-type
        cls_jalr   = 2'd3       // indirect jump, returns included
    } inst_class_e;

endpackage

/* hdl/bpu_pred_pkg.sv */
`include "bpu_consts.svh"

// predictor state types
package bpu_pred_pkg;

    // global history, newest outcome in bit 0
    typedef logic [`BPU_GHIST_W-1:0] ghist_t;

    // 2-bit saturating counter, msb set means taken
    // 00 strong nt, 01 weak nt, 10 weak t, 11 strong t
    typedef logic [1:0] ctr_t;

    // tagged table tag and index
    typedef logic [`BPU_TAG_W-1:0]      tag_t;
    typedef logic [`BPU_TAGE_IDX_W-1:0] tidx_t;

    // bimodal index
    typedef logic [`BPU_BIM_IDX_W-1:0] bidx_t;

    // which table supplied the direction
    typedef enum logic [1:0] {
        prov_bimodal = 2'd0,
        prov_t0      = 2'd1,
        prov_t1      = 2'd2
    } provider_e;

endpackage

/* hdl/inst_predecode.sv */
`include "bpu_consts.svh"

module inst_predecode (
    input  bpu_isa_pkg::inst_t       if_inst_i,
    output bpu_isa_pkg::inst_class_e inst_class_o,
    output bpu_isa_pkg::addr_t       b_imm_o,
    output bpu_isa_pkg::addr_t       j_imm_o
);

    logic [6:0] opcode;
    logic       sign;

    assign opcode = if_inst_i[6:0];
    assign sign   = if_inst_i[31];     // imm sign lives in bit 31 for both formats

    always_comb begin
        case (opcode)
            `BPU_OP_BRANCH: inst_class_o = bpu_isa_pkg::cls_branch;
            `BPU_OP_JAL:    inst_class_o = bpu_isa_pkg::cls_jal;
            `BPU_OP_JALR:   inst_class_o = bpu_isa_pkg::cls_jalr;
            default:        inst_class_o = bpu_isa_pkg::cls_other;
        endcase
    end

    // B-type offset, 13 bits, lsb implied zero
    assign b_imm_o = {
        {(`BPU_XLEN-12){sign}},
        if_inst_i[7],
        if_inst_i[30:25],
        if_inst_i[11:8],
        1'b0
    };

    // J-type offset, 21 bits, lsb implied zero
    assign j_imm_o = {
        {(`BPU_XLEN-20){sign}},
        if_inst_i[19:12],
        if_inst_i[20],
        if_inst_i[30:21],
        1'b0
    };

endmodule

/* hdl/tage_dir.sv */
`include "bpu_consts.svh"

module tage_dir (
    input  logic                 clk,
    input  logic                 rst,
    input  bpu_isa_pkg::addr_t   if_pc_i,
    input  bpu_pred_pkg::ghist_t ghist_i,
    output logic                 dir_taken_o,
    input  logic                 ex_valid_i,
    input  logic                 ex_taken_i,
    input  logic                 ex_pred_ok_i,
    input  bpu_isa_pkg::addr_t   ex_pc_i,
    input  bpu_pred_pkg::ghist_t ex_history_i
);

    // hashes, identical at lookup and update
    function automatic bpu_pred_pkg::bidx_t bim_idx(bpu_isa_pkg::addr_t pc);
        return pc[`BPU_BIM_IDX_W:1];
    endfunction

    function automatic bpu_pred_pkg::tidx_t t0_idx(bpu_isa_pkg::addr_t pc,
                                                   bpu_pred_pkg::ghist_t h);
        return pc[`BPU_TAGE_IDX_W-1:0] ^ h[`BPU_TAGE_IDX_W-1:0];   // short history
    endfunction

    function automatic bpu_pred_pkg::tidx_t t1_idx(bpu_isa_pkg::addr_t pc,
                                                   bpu_pred_pkg::ghist_t h);
        return pc[`BPU_TAGE_IDX_W-1:0] ^ h[`BPU_GHIST_W-1 -: `BPU_TAGE_IDX_W];
    endfunction

    function automatic bpu_pred_pkg::tag_t t0_tag_f(bpu_isa_pkg::addr_t pc,
                                                    bpu_pred_pkg::ghist_t h);
        return pc[`BPU_TAGE_IDX_W +: `BPU_TAG_W] ^ h[`BPU_GHIST_W-1 -: `BPU_TAG_W];
    endfunction

    function automatic bpu_pred_pkg::tag_t t1_tag_f(bpu_isa_pkg::addr_t pc,
                                                    bpu_pred_pkg::ghist_t h);
        return pc[`BPU_TAGE_IDX_W +: `BPU_TAG_W]
             ^ bpu_pred_pkg::tag_t'(h[`BPU_TAGE_IDX_W-1:0]);       // zero-extended
    endfunction

    // partial match on the upper tag bits only
    function automatic logic ptag_eq(bpu_pred_pkg::tag_t a, bpu_pred_pkg::tag_t b);
        return a[`BPU_TAG_W-1 -: `BPU_PTAG_W] == b[`BPU_TAG_W-1 -: `BPU_PTAG_W];
    endfunction

    // longest history wins
    function automatic bpu_pred_pkg::provider_e pick(logic t1_hit, logic t0_hit);
        if (t1_hit)
            return bpu_pred_pkg::prov_t1;
        if (t0_hit)
            return bpu_pred_pkg::prov_t0;
        return bpu_pred_pkg::prov_bimodal;
    endfunction

    function automatic bpu_pred_pkg::ctr_t ctr_step(bpu_pred_pkg::ctr_t c, logic up);
        if (up && c != 2'b11)
            return c + 2'd1;
        if (!up && c != 2'b00)
            return c - 2'd1;
        return c;
    endfunction

    bpu_pred_pkg::ctr_t bim_ctr [`BPU_BIM_ENTRIES];
    bpu_pred_pkg::ctr_t t0_ctr  [`BPU_TAGE_ENTRIES];
    bpu_pred_pkg::tag_t t0_tag  [`BPU_TAGE_ENTRIES];
    bpu_pred_pkg::ctr_t t1_ctr  [`BPU_TAGE_ENTRIES];
    bpu_pred_pkg::tag_t t1_tag  [`BPU_TAGE_ENTRIES];

    // lookup side
    bpu_pred_pkg::bidx_t     lk_bim;
    bpu_pred_pkg::tidx_t     lk_t0;
    bpu_pred_pkg::tidx_t     lk_t1;
    bpu_pred_pkg::provider_e lk_prov;

    // update side
    bpu_pred_pkg::bidx_t     up_bim;
    bpu_pred_pkg::tidx_t     up_t0;
    bpu_pred_pkg::tidx_t     up_t1;
    bpu_pred_pkg::tag_t      up_t0_tag;
    bpu_pred_pkg::tag_t      up_t1_tag;
    bpu_pred_pkg::provider_e up_prov;

    assign lk_bim  = bim_idx(if_pc_i);
    assign lk_t0   = t0_idx(if_pc_i, ghist_i);
    assign lk_t1   = t1_idx(if_pc_i, ghist_i);
    assign lk_prov = pick(ptag_eq(t1_tag[lk_t1], t1_tag_f(if_pc_i, ghist_i)),
                          ptag_eq(t0_tag[lk_t0], t0_tag_f(if_pc_i, ghist_i)));

    always_comb begin
        case (lk_prov)
            bpu_pred_pkg::prov_t1: dir_taken_o = t1_ctr[lk_t1][1];
            bpu_pred_pkg::prov_t0: dir_taken_o = t0_ctr[lk_t0][1];
            default:               dir_taken_o = bim_ctr[lk_bim][1];
        endcase
    end

    // provider recomputed from the snapshot history, no stored copy needed
    assign up_bim    = bim_idx(ex_pc_i);
    assign up_t0     = t0_idx(ex_pc_i, ex_history_i);
    assign up_t1     = t1_idx(ex_pc_i, ex_history_i);
    assign up_t0_tag = t0_tag_f(ex_pc_i, ex_history_i);
    assign up_t1_tag = t1_tag_f(ex_pc_i, ex_history_i);
    assign up_prov   = pick(ptag_eq(t1_tag[up_t1], up_t1_tag),
                            ptag_eq(t0_tag[up_t0], up_t0_tag));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `BPU_BIM_ENTRIES; i++) begin
                bim_ctr[i] <= 2'b01;                // weak not taken
            end
            for (int i = 0; i < `BPU_TAGE_ENTRIES; i++) begin
                t0_ctr[i] <= 2'b01;
                t0_tag[i] <= '0;
                t1_ctr[i] <= 2'b01;
                t1_tag[i] <= '0;
            end
        end else if (ex_valid_i) begin
            bim_ctr[up_bim] <= ctr_step(bim_ctr[up_bim], ex_taken_i);   // always trained
            if (ex_pred_ok_i) begin
                case (up_prov)
                    bpu_pred_pkg::prov_t1: t1_ctr[up_t1] <= ctr_step(t1_ctr[up_t1], ex_taken_i);
                    bpu_pred_pkg::prov_t0: t0_ctr[up_t0] <= ctr_step(t0_ctr[up_t0], ex_taken_i);
                    default: ;
                endcase
            end else begin
                case (up_prov)
                    // tagged provider was wrong, jump to the strong side
                    bpu_pred_pkg::prov_t1: t1_ctr[up_t1] <= ex_taken_i ? 2'b11 : 2'b00;
                    bpu_pred_pkg::prov_t0: t0_ctr[up_t0] <= ex_taken_i ? 2'b11 : 2'b00;
                    default: begin
                        // bimodal miss, allocate T1 first
                        if (t1_tag[up_t1] != up_t1_tag) begin
                            t1_tag[up_t1] <= up_t1_tag;
                            t1_ctr[up_t1] <= ex_taken_i ? 2'b10 : 2'b01;
                        end else if (t0_tag[up_t0] != up_t0_tag) begin
                            t0_tag[up_t0] <= up_t0_tag;
                            t0_ctr[up_t0] <= ex_taken_i ? 2'b10 : 2'b01;
                        end
                    end
                endcase
            end
        end
    end

    // EX must resolve a direction on every strobe
    a_ex_taken_known: assert property (
        @(posedge clk) disable iff (rst) ex_valid_i |-> !$isunknown(ex_taken_i)
    );

endmodule

/* hdl/btb.sv */
`include "bpu_consts.svh"

module btb (
    input  logic               clk,
    input  logic               rst,
    input  bpu_isa_pkg::addr_t if_pc_i,
    output logic               hit_o,
    output bpu_isa_pkg::addr_t target_o,
    input  logic               ex_valid_i,
    input  logic               ex_taken_i,
    input  bpu_isa_pkg::addr_t ex_pc_i,
    input  bpu_isa_pkg::addr_t ex_target_i
);

    logic [`BPU_BTB_TAG_W-1:0]  tag_mem [`BPU_BTB_ENTRIES];
    bpu_isa_pkg::addr_t         tgt_mem [`BPU_BTB_ENTRIES];
    logic [`BPU_BTB_ENTRIES-1:0] valid_q;

    logic [`BPU_BTB_IDX_W-1:0]  lk_idx;
    logic [`BPU_BTB_TAG_W-1:0]  lk_tag;
    logic [`BPU_BTB_IDX_W-1:0]  up_idx;
    logic [`BPU_BTB_TAG_W-1:0]  up_tag;
    logic                       fill;

    // word aligned, index starts at pc bit 2
    assign lk_idx = if_pc_i[2 +: `BPU_BTB_IDX_W];
    assign lk_tag = if_pc_i[`BPU_XLEN-1 -: `BPU_BTB_TAG_W];
    assign up_idx = ex_pc_i[2 +: `BPU_BTB_IDX_W];
    assign up_tag = ex_pc_i[`BPU_XLEN-1 -: `BPU_BTB_TAG_W];

    assign fill = ex_valid_i & ex_taken_i;       // only taken outcomes carry a target

    assign hit_o    = valid_q[lk_idx] && (tag_mem[lk_idx] == lk_tag);
    assign target_o = tgt_mem[lk_idx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= '0;
        end else if (fill) begin
            valid_q[up_idx] <= 1'b1;
        end
    end

    // tag and target, overwritten in place
    always_ff @(posedge clk) begin
        if (fill) begin
            tag_mem[up_idx] <= up_tag;
            tgt_mem[up_idx] <= ex_target_i;
        end
    end

    a_ex_pc_known: assert property (
        @(posedge clk) disable iff (rst) ex_valid_i |-> !$isunknown(ex_pc_i)
    );

endmodule

/* hdl/next_pc_select.sv */
module next_pc_select (
    input  bpu_isa_pkg::addr_t       if_pc_i,
    input  bpu_isa_pkg::inst_class_e inst_class_i,
    input  bpu_isa_pkg::addr_t       b_imm_i,
    input  bpu_isa_pkg::addr_t       j_imm_i,
    input  logic                     dir_taken_i,
    input  logic                     btb_hit_i,
    input  bpu_isa_pkg::addr_t       btb_target_i,
    output logic                     is_ctrl_o,
    output logic                     pred_taken_o,
    output bpu_isa_pkg::addr_t       pred_pc_o
);

    bpu_isa_pkg::addr_t seq_pc;
    bpu_isa_pkg::addr_t jal_pc;
    bpu_isa_pkg::addr_t br_pc;

    assign seq_pc = if_pc_i + bpu_isa_pkg::addr_t'(4);
    assign jal_pc = btb_hit_i ? btb_target_i : if_pc_i + j_imm_i;   // btb first
    assign br_pc  = btb_hit_i ? btb_target_i : if_pc_i + b_imm_i;

    always_comb begin
        is_ctrl_o    = 1'b1;
        pred_taken_o = 1'b0;
        pred_pc_o    = seq_pc;
        case (inst_class_i)
            bpu_isa_pkg::cls_jal: begin
                pred_taken_o = 1'b1;            // unconditional
                pred_pc_o    = jal_pc;
            end
            bpu_isa_pkg::cls_branch: begin
                pred_taken_o = dir_taken_i;
                if (dir_taken_i) begin
                    pred_pc_o = br_pc;
                end
            end
            bpu_isa_pkg::cls_jalr: begin
                // no way to form the target without the btb
                if (btb_hit_i) begin
                    pred_taken_o = 1'b1;
                    pred_pc_o    = btb_target_i;
                end
            end
            default: begin
                is_ctrl_o = 1'b0;
            end
        endcase
    end

    // a taken prediction only ever comes from a control class
    a_taken_is_ctrl: assert #0 (!pred_taken_o || is_ctrl_o)
        else $error("pred_taken_o without is_ctrl_o");

endmodule

/* hdl/bpu_top.sv */
`include "bpu_consts.svh"

module bpu_top (
    input  logic                 clk,
    input  logic                 rst,
    input  bpu_isa_pkg::addr_t   if_pc_i,
    input  bpu_isa_pkg::inst_t   if_inst_i,
    input  logic                 ex_valid_i,
    input  logic                 ex_taken_i,
    input  logic                 ex_pred_ok_i,
    input  bpu_isa_pkg::addr_t   ex_pc_i,
    input  bpu_pred_pkg::ghist_t ex_history_i,
    input  bpu_isa_pkg::addr_t   ex_target_i,
    output logic                 is_ctrl_o,
    output logic                 pred_taken_o,
    output bpu_isa_pkg::addr_t   pred_pc_o,
    output bpu_pred_pkg::ghist_t history_o
);

    bpu_pred_pkg::ghist_t     ghist_q;
    bpu_isa_pkg::inst_class_e inst_class;
    bpu_isa_pkg::addr_t       b_imm;
    bpu_isa_pkg::addr_t       j_imm;
    logic                     dir_taken;
    logic                     btb_hit;
    bpu_isa_pkg::addr_t       btb_target;

    // resolved outcomes only, shifted in at bit 0
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ghist_q <= '0;
        end else if (ex_valid_i) begin
            ghist_q <= {ghist_q[`BPU_GHIST_W-2:0], ex_taken_i};
        end
    end

    assign history_o = ghist_q;

    inst_predecode u_predecode (
        .if_inst_i    (if_inst_i),
        .inst_class_o (inst_class),
        .b_imm_o      (b_imm),
        .j_imm_o      (j_imm)
    );

    tage_dir u_tage (
        .clk          (clk),
        .rst          (rst),
        .if_pc_i      (if_pc_i),
        .ghist_i      (ghist_q),
        .dir_taken_o  (dir_taken),
        .ex_valid_i   (ex_valid_i),
        .ex_taken_i   (ex_taken_i),
        .ex_pred_ok_i (ex_pred_ok_i),
        .ex_pc_i      (ex_pc_i),
        .ex_history_i (ex_history_i)
    );

    btb u_btb (
        .clk         (clk),
        .rst         (rst),
        .if_pc_i     (if_pc_i),
        .hit_o       (btb_hit),
        .target_o    (btb_target),
        .ex_valid_i  (ex_valid_i),
        .ex_taken_i  (ex_taken_i),
        .ex_pc_i     (ex_pc_i),
        .ex_target_i (ex_target_i)
    );

    next_pc_select u_sel (
        .if_pc_i      (if_pc_i),
        .inst_class_i (inst_class),
        .b_imm_i      (b_imm),
        .j_imm_i      (j_imm),
        .dir_taken_i  (dir_taken),
        .btb_hit_i    (btb_hit),
        .btb_target_i (btb_target),
        .is_ctrl_o    (is_ctrl_o),
        .pred_taken_o (pred_taken_o),
        .pred_pc_o    (pred_pc_o)
    );

endmodule

/* dv/bpu_ref_model.svh */
`ifndef BPU_REF_MODEL_SVH
`define BPU_REF_MODEL_SVH

`include "bpu_consts.svh"

// shadow copy of the predictor state
bpu_pred_pkg::ctr_t   sh_bim     [`BPU_BIM_ENTRIES];
bpu_pred_pkg::ctr_t   sh_t0_ctr  [`BPU_TAGE_ENTRIES];
bpu_pred_pkg::tag_t   sh_t0_tag  [`BPU_TAGE_ENTRIES];
bpu_pred_pkg::ctr_t   sh_t1_ctr  [`BPU_TAGE_ENTRIES];
bpu_pred_pkg::tag_t   sh_t1_tag  [`BPU_TAGE_ENTRIES];
logic                 sh_btb_v   [`BPU_BTB_ENTRIES];
logic [21:0]          sh_btb_tag [`BPU_BTB_ENTRIES];
bpu_isa_pkg::addr_t   sh_btb_tgt [`BPU_BTB_ENTRIES];
bpu_pred_pkg::ghist_t sh_hist;

function automatic void clear_shadow();
    for (int i = 0; i < `BPU_BIM_ENTRIES; i++) begin
        sh_bim[i] = 2'b01;
    end
    for (int i = 0; i < `BPU_TAGE_ENTRIES; i++) begin
        sh_t0_ctr[i] = 2'b01;
        sh_t0_tag[i] = '0;
        sh_t1_ctr[i] = 2'b01;
        sh_t1_tag[i] = '0;
    end
    for (int i = 0; i < `BPU_BTB_ENTRIES; i++) begin
        sh_btb_v[i]   = 1'b0;
        sh_btb_tag[i] = '0;
        sh_btb_tgt[i] = '0;
    end
    sh_hist = '0;
endfunction

function automatic bpu_pred_pkg::tag_t t0_tag_of(input bpu_isa_pkg::addr_t pc,
                                                 input bpu_pred_pkg::ghist_t h);
    return pc[17:8] ^ h[15:6];
endfunction

function automatic bpu_pred_pkg::tag_t t1_tag_of(input bpu_isa_pkg::addr_t pc,
                                                 input bpu_pred_pkg::ghist_t h);
    return pc[17:8] ^ {2'b00, h[7:0]};
endfunction

// upper 6 tag bits decide a hit, T1 before T0
function automatic bpu_pred_pkg::provider_e provider_of(input bpu_isa_pkg::addr_t pc,
                                                        input bpu_pred_pkg::ghist_t h);
    bpu_pred_pkg::tag_t g0;
    bpu_pred_pkg::tag_t g1;
    g0 = t0_tag_of(pc, h);
    g1 = t1_tag_of(pc, h);
    if (sh_t1_tag[pc[7:0] ^ h[15:8]][9:4] == g1[9:4]) begin
        return bpu_pred_pkg::prov_t1;
    end
    if (sh_t0_tag[pc[7:0] ^ h[7:0]][9:4] == g0[9:4]) begin
        return bpu_pred_pkg::prov_t0;
    end
    return bpu_pred_pkg::prov_bimodal;
endfunction

function automatic logic direction_of(input bpu_isa_pkg::addr_t pc,
                                      input bpu_pred_pkg::ghist_t h);
    case (provider_of(pc, h))
        bpu_pred_pkg::prov_t1: return sh_t1_ctr[pc[7:0] ^ h[15:8]][1];
        bpu_pred_pkg::prov_t0: return sh_t0_ctr[pc[7:0] ^ h[7:0]][1];
        default:               return sh_bim[pc[9:1]][1];
    endcase
endfunction

function automatic bpu_pred_pkg::ctr_t sat_step(input bpu_pred_pkg::ctr_t c, input logic up);
    if (up) begin
        return (c == 2'b11) ? c : c + 2'b01;
    end
    return (c == 2'b00) ? c : c - 2'b01;
endfunction

// expected prediction for one fetch, from the live shadow history
function automatic void expected_pred(input bpu_isa_pkg::addr_t pc,
                                      input bpu_isa_pkg::inst_t inst,
                                      output logic ctrl, output logic tk,
                                      output bpu_isa_pkg::addr_t npc);
    bpu_isa_pkg::addr_t b_off;
    bpu_isa_pkg::addr_t j_off;
    logic [7:0]         bi;
    logic               hit;
    b_off = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    j_off = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    bi    = pc[9:2];
    hit   = sh_btb_v[bi] && (sh_btb_tag[bi] == pc[31:10]);
    ctrl  = 1'b1;
    tk    = 1'b0;
    npc   = pc + 32'd4;
    case (inst[6:0])
        `BPU_OP_JAL: begin
            tk  = 1'b1;
            npc = hit ? sh_btb_tgt[bi] : pc + j_off;
        end
        `BPU_OP_BRANCH: begin
            tk = direction_of(pc, sh_hist);
            if (tk) begin
                npc = hit ? sh_btb_tgt[bi] : pc + b_off;
            end
        end
        `BPU_OP_JALR: begin
            if (hit) begin      // no target without the btb
                tk  = 1'b1;
                npc = sh_btb_tgt[bi];
            end
        end
        default: ctrl = 1'b0;
    endcase
endfunction

// one EX strobe applied to the shadow state
task automatic apply_update(input logic tk, input logic ok, input bpu_isa_pkg::addr_t pc,
                            input bpu_pred_pkg::ghist_t h, input bpu_isa_pkg::addr_t tgt);
    bpu_pred_pkg::provider_e p;
    bpu_pred_pkg::tidx_t     i0;
    bpu_pred_pkg::tidx_t     i1;
    i0 = pc[7:0] ^ h[7:0];
    i1 = pc[7:0] ^ h[15:8];
    p  = provider_of(pc, h);
    sh_bim[pc[9:1]] = sat_step(sh_bim[pc[9:1]], tk);
    if (ok) begin
        if (p == bpu_pred_pkg::prov_t1) begin
            sh_t1_ctr[i1] = sat_step(sh_t1_ctr[i1], tk);
        end else if (p == bpu_pred_pkg::prov_t0) begin
            sh_t0_ctr[i0] = sat_step(sh_t0_ctr[i0], tk);
        end
    end else if (p == bpu_pred_pkg::prov_t1) begin
        sh_t1_ctr[i1] = tk ? 2'b11 : 2'b00;
    end else if (p == bpu_pred_pkg::prov_t0) begin
        sh_t0_ctr[i0] = tk ? 2'b11 : 2'b00;
    end else if (sh_t1_tag[i1] != t1_tag_of(pc, h)) begin
        sh_t1_tag[i1] = t1_tag_of(pc, h);       // allocate in the longer table
        sh_t1_ctr[i1] = tk ? 2'b10 : 2'b01;
    end else if (sh_t0_tag[i0] != t0_tag_of(pc, h)) begin
        sh_t0_tag[i0] = t0_tag_of(pc, h);
        sh_t0_ctr[i0] = tk ? 2'b10 : 2'b01;
    end
    if (tk) begin
        sh_btb_v[pc[9:2]]   = 1'b1;
        sh_btb_tag[pc[9:2]] = pc[31:10];
        sh_btb_tgt[pc[9:2]] = tgt;
    end
    sh_hist = {sh_hist[14:0], tk};
endtask

`endif

/* dv/bpu_tb.sv */
`include "bpu_consts.svh"

module bpu_tb;

    localparam int reset_cycles    = 8;
    localparam int directed_cycles = 80;    // upper bound for the directed tests
    localparam int random_cycles   = 400;
    localparam int time_limit      = (reset_cycles + directed_cycles + random_cycles) * 4 + 400;

    localparam bpu_isa_pkg::inst_t nop_inst  = 32'h0000_0013;
    localparam bpu_isa_pkg::inst_t jalr_inst = {12'd0, 5'd1, 3'b000, 5'd0, `BPU_OP_JALR}; // ret

    logic                 clk = 1'b0;
    logic                 rst;
    bpu_isa_pkg::addr_t   if_pc;
    bpu_isa_pkg::inst_t   if_inst;
    logic                 ex_valid;
    logic                 ex_taken;
    logic                 ex_pred_ok;
    bpu_isa_pkg::addr_t   ex_pc;
    bpu_pred_pkg::ghist_t ex_history;
    bpu_isa_pkg::addr_t   ex_target;
    logic                 is_ctrl;
    logic                 pred_taken;
    bpu_isa_pkg::addr_t   pred_pc;
    bpu_pred_pkg::ghist_t history;

    int                   errors   = 0;
    int                   err_mark = 0;
    int                   checks   = 0;
    int                   tests    = 0;
    logic [16:0]          lfsr_q   = 17'd79582;
    bpu_pred_pkg::ghist_t hist_now = '0;    // stimulus side view of the history

    `include "bpu_ref_model.svh"

    bpu_top uut (
        .clk          (clk),
        .rst          (rst),
        .if_pc_i      (if_pc),
        .if_inst_i    (if_inst),
        .ex_valid_i   (ex_valid),
        .ex_taken_i   (ex_taken),
        .ex_pred_ok_i (ex_pred_ok),
        .ex_pc_i      (ex_pc),
        .ex_history_i (ex_history),
        .ex_target_i  (ex_target),
        .is_ctrl_o    (is_ctrl),
        .pred_taken_o (pred_taken),
        .pred_pc_o    (pred_pc),
        .history_o    (history)
    );

    always #2 clk = ~clk;

    // taps of x^17 + x^14 + 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_q[16] ^ lfsr_q[13];
        lfsr_q = {lfsr_q[15:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_bit()};
        end
        return v;
    endfunction

    // small pool so pcs collide in the tables
    function automatic bpu_isa_pkg::addr_t pool_pc();
        bpu_isa_pkg::addr_t pc;
        pc = '0;
        pc[17:16] = 2'(rand_bits(2));
        pc[7:2] = 6'(rand_bits(6));
        return pc;
    endfunction

    function automatic bpu_isa_pkg::inst_t enc_jal(input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, `BPU_OP_JAL};
    endfunction

    function automatic bpu_isa_pkg::inst_t enc_branch(input logic [12:0] imm);
        return {imm[12], imm[10:5], 5'd2, 5'd1, 3'b000, imm[4:1], imm[11], `BPU_OP_BRANCH};
    endfunction

    task automatic log_mismatch(input string name, input logic [31:0] exp, input logic [31:0] got);
        $display("FAIL %s expected %h got %h", name, exp, got);
        errors++;
    endtask

    task automatic fetch(input bpu_isa_pkg::addr_t pc, input bpu_isa_pkg::inst_t inst);
        @(negedge clk);
        if_pc    = pc;
        if_inst  = inst;
        ex_valid = 1'b0;
    endtask

    // one EX strobe while the fetch inputs hold
    task automatic strobe(input logic tk, input logic ok, input bpu_isa_pkg::addr_t pc,
                          input bpu_pred_pkg::ghist_t h, input bpu_isa_pkg::addr_t tgt);
        @(negedge clk);
        ex_valid   = 1'b1;
        ex_taken   = tk;
        ex_pred_ok = ok;
        ex_pc      = pc;
        ex_history = h;
        ex_target  = tgt;
        hist_now   = {hist_now[14:0], tk};
    endtask

    task automatic expect_pred(input logic ctrl, input logic tk, input bpu_isa_pkg::addr_t pc);
        #1;
        checks++;
        assert (is_ctrl === ctrl) else log_mismatch("is_ctrl_o", ctrl, is_ctrl);
        assert (pred_taken === tk) else log_mismatch("pred_taken_o", tk, pred_taken);
        assert (pred_pc === pc) else log_mismatch("pred_pc_o", pc, pred_pc);
    endtask

    task automatic check_cycle();
        logic               e_ctrl;
        logic               e_tk;
        bpu_isa_pkg::addr_t e_pc;
        expected_pred(if_pc, if_inst, e_ctrl, e_tk, e_pc);
        checks++;
        assert (is_ctrl === e_ctrl) else log_mismatch("is_ctrl_o", e_ctrl, is_ctrl);
        assert (pred_taken === e_tk) else log_mismatch("pred_taken_o", e_tk, pred_taken);
        assert (pred_pc === e_pc) else log_mismatch("pred_pc_o", e_pc, pred_pc);
        assert (history === sh_hist) else log_mismatch("history_o", sh_hist, history);
        if (ex_valid === 1'b1) begin
            apply_update(ex_taken, ex_pred_ok, ex_pc, ex_history, ex_target);  // edge ahead
        end
    endtask

    // sample one time unit before each rising edge
    always begin
        @(negedge clk);
        #1;
        if (rst === 1'b0) begin
            check_cycle();
        end
    end

    task automatic close_test(input string name);
        @(posedge clk);
        tests++;
        if (errors == err_mark) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    task automatic nonctrl_fetches();
        for (int i = 0; i < 8; i++) begin
            fetch(32'h0000_1000 + 32'(i * 4), (i % 2) ? 32'h1234_5037 : nop_inst);
            expect_pred(1'b0, 1'b0, 32'h0000_1004 + 32'(i * 4));
        end
        close_test("non-control fetch");
    endtask

    task automatic jump_targets();
        bpu_isa_pkg::addr_t pc_j;
        bpu_isa_pkg::addr_t pc_r;
        pc_j = 32'h0000_2040;
        pc_r = 32'h0000_3100;
        fetch(pc_j, enc_jal(21'h0_0100));
        expect_pred(1'b1, 1'b1, pc_j + 32'h100);
        fetch(pc_j, enc_jal(21'h1F_FF00));      // backward
        expect_pred(1'b1, 1'b1, pc_j - 32'h100);
        strobe(1'b1, 1'b1, pc_j, hist_now, 32'h0000_8000);
        fetch(pc_j, enc_jal(21'h0_0100));
        expect_pred(1'b1, 1'b1, 32'h0000_8000);
        fetch(pc_r, jalr_inst);
        expect_pred(1'b1, 1'b0, pc_r + 32'd4);
        strobe(1'b1, 1'b1, pc_r, hist_now, 32'h0000_9abc);
        fetch(pc_r, jalr_inst);
        expect_pred(1'b1, 1'b1, 32'h0000_9abc);
        close_test("jal and jalr targets");
    endtask

    task automatic branch_training();
        bpu_isa_pkg::addr_t pc_b;
        bpu_isa_pkg::addr_t pc_c;
        bpu_isa_pkg::addr_t pc_alias;
        pc_b     = 32'h0003_4200;
        pc_c     = 32'h0002_4700;
        pc_alias = 32'h0001_4700;   // shares the bimodal slot of pc_c with another btb tag
        fetch(pc_b, enc_branch(13'h0040));
        expect_pred(1'b1, 1'b0, pc_b + 32'd4);
        repeat (2) strobe(1'b1, 1'b1, pc_b, hist_now, 32'h0000_a000);
        fetch(pc_b, enc_branch(13'h0040));
        expect_pred(1'b1, 1'b1, 32'h0000_a000);
        repeat (2) strobe(1'b1, 1'b1, pc_alias, hist_now, 32'h0000_b000);
        fetch(pc_c, enc_branch(13'h1FC0));
        expect_pred(1'b1, 1'b1, pc_c - 32'h40);
        close_test("conditional branch training");
    endtask

    task automatic history_shift();
        bpu_pred_pkg::ghist_t pattern;
        pattern = 16'hA5C3;
        for (int i = 15; i >= 0; i--) begin
            strobe(pattern[i], 1'b1, 32'h0000_5000, hist_now, 32'h0000_c000);
        end
        fetch(32'h0000_5000, nop_inst);
        #1;
        checks++;
        assert (history === pattern) else log_mismatch("history_o", pattern, history);
        close_test("global history shift");
    endtask

    // bimodal says taken while the allocated T1 entry is weak not taken
    task automatic tagged_allocation();
        bpu_isa_pkg::addr_t pc_a;
        pc_a = 32'h0003_7280;
        repeat (2) strobe(1'b1, 1'b1, pc_a, hist_now, 32'h0000_d000);
        strobe(1'b0, 1'b0, pc_a, {hist_now[14:0], 1'b0}, 32'h0000_d000);
        fetch(pc_a, enc_branch(13'h0020));
        expect_pred(1'b1, 1'b0, pc_a + 32'd4);
        close_test("tagged allocation");
    endtask

    task automatic random_mix();
        bpu_isa_pkg::inst_t inst;
        logic [1:0]         kind;
        for (int n = 0; n < random_cycles; n++) begin
            inst = rand_bits(32);
            kind = 2'(rand_bits(2));
            case (kind)
                2'd0: inst[6:0] = 7'b0110011;
                2'd1: inst[6:0] = `BPU_OP_BRANCH;
                2'd2: inst[6:0] = `BPU_OP_JAL;
                default: inst[6:0] = `BPU_OP_JALR;
            endcase
            @(negedge clk);
            if_pc      = pool_pc();
            if_inst    = inst;
            ex_valid   = 1'(rand_bits(1));
            ex_taken   = 1'(rand_bits(1));
            ex_pred_ok = 1'(rand_bits(1));
            ex_pc      = pool_pc();
            ex_history = 16'(rand_bits(16));
            ex_target  = rand_bits(32) & 32'hFFFF_FFFC;
        end
        close_test("random mix");
    endtask

    initial begin
        rst        = 1'b1;
        if_pc      = '0;
        if_inst    = nop_inst;
        ex_valid   = 1'b0;
        ex_taken   = 1'b0;
        ex_pred_ok = 1'b0;
        ex_pc      = '0;
        ex_history = '0;
        ex_target  = '0;
        clear_shadow();
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        nonctrl_fetches();
        jump_targets();
        branch_training();
        history_shift();
        tagged_allocation();
        random_mix();
        $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    initial begin
        #(time_limit);
        $display("timeout: the run did not finish within %0d time units", time_limit);
        $display("Verification failed");
        $finish;
    end

endmodule

/* flist.f */
+incdir+hdl
+incdir+dv
hdl/bpu_isa_pkg.sv
hdl/bpu_pred_pkg.sv
hdl/inst_predecode.sv
hdl/tage_dir.sv
hdl/btb.sv
hdl/next_pc_select.sv
hdl/bpu_top.sv
dv/bpu_tb.sv

/* Bender.yml */
package:
  name: bpu

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/bpu_isa_pkg.sv
      - hdl/bpu_pred_pkg.sv
      - hdl/inst_predecode.sv
      - hdl/tage_dir.sv
      - hdl/btb.sv
      - hdl/next_pc_select.sv
      - hdl/bpu_top.sv
  - target: test
    include_dirs:
      - hdl
      - dv
    files:
      - dv/bpu_tb.sv
